// File: common/fetch_settings.svh
// fetch front end settings: history width, return stack depth and reset pc
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// global history bits, also the counter table index width (1024 counters)
`define FETCH_GHR_BITS 10

// return stack entries, pointer is 4 bits wide
`define FETCH_RAS_DEPTH 16

// first fetch address out of reset
`define FETCH_RESET_PC 32'h0000_1000

`endif

// File: common/fetch_pkg.sv
// fetch types: control opcodes, the B/J instruction union and the grouped fetch output
package fetch_pkg;

    // control-flow opcodes seen by predecode
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // B-type layout, rs1 is also the JALR base register
    typedef struct packed {
        logic        imm12;    // sign bit
        logic [5:0]  imm10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        opcode_e     opcode;
    } b_view_t;

    // J-type layout, rd is shared with I-type (JALR)
    typedef struct packed {
        logic        imm20;    // sign bit
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } j_view_t;

    // one fetched word, decoded both ways
    typedef union packed {
        b_view_t b;
        j_view_t j;
    } instr_u;

    // what fetch hands on per cycle
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        pred_taken; // jump, or branch predicted taken
        logic        branch;
        logic        jump;
        logic [3:0]  ras_ptr;    // stack pointer before this instruction
        logic [31:0] next_pc;
    } fetch_out_t;

endpackage

// File: common/predecode_if.sv
// predecode results bus from the decode step to the return stack and pc selection
`timescale 1ns/1ps

interface predecode_if;

    logic        branch;        // conditional branch
    logic        jump;          // JAL
    logic        jalr;
    logic        push;          // ras push hint
    logic        pop;           // ras pop hint
    logic [31:0] branch_target; // pc + B imm
    logic [31:0] jal_target;    // pc + J imm

    // driver side
    modport pd (
        output branch, jump, jalr, push, pop, branch_target, jal_target
    );

    // return stack only cares about the hints
    modport pred (
        input push, pop
    );

    // pc selection sees everything
    modport sel (
        input branch, jump, jalr, push, pop, branch_target, jal_target
    );

endinterface

// File: fetch/predecode.sv
// predecode: classifies control instructions, builds B/J targets and ras push/pop hints
`timescale 1ns/1ps

module predecode (
    predecode_if.pd          iface,
    input  logic [31:0]      pc,
    input  fetch_pkg::instr_u instr
);

    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic        rd_link;   // rd is x1 or x5
    logic        rs1_link;  // rs1 is x1 or x5

    // opcode sits in the same place in both views
    assign iface.branch = (instr.b.opcode == fetch_pkg::OPC_BRANCH);
    assign iface.jump   = (instr.j.opcode == fetch_pkg::OPC_JAL);
    assign iface.jalr   = (instr.b.opcode == fetch_pkg::OPC_JALR);

    // immediates rebuilt from the scattered fields, sign extended
    assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    assign iface.branch_target = pc + b_imm;
    assign iface.jal_target    = pc + j_imm;

    assign rd       = instr.j.rd;
    assign rs1      = instr.b.rs1;
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // link register hint table from the RISC-V spec
    always_comb begin
        iface.push = 1'b0;
        iface.pop  = 1'b0;
        if (iface.jump) begin
            iface.push = rd_link; // call
        end else if (iface.jalr) begin
            iface.push = rd_link;
            if (!rd_link && rs1_link) begin
                iface.pop = 1'b1; // plain return
            end else if (rd_link && rs1_link && (rd != rs1)) begin
                iface.pop = 1'b1; // coroutine swap, pop then push
            end
        end
    end

endmodule

// File: fetch/gshare_predictor.sv
// gshare branch predictor: commit-updated global history over 2-bit counters
`timescale 1ns/1ps
`include "fetch_settings.svh"

module gshare_predictor (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] pc,
    input  logic        commit_valid,  // a conditional branch retired
    input  logic        commit_taken,  // its resolved direction
    input  logic [31:0] commit_pc,
    output logic        prediction
);

    localparam int IDX_W   = `FETCH_GHR_BITS;
    localparam int ENTRIES = 1 << IDX_W;

    logic [IDX_W-1:0] ghr;              // oldest outcome in msb
    logic [1:0]       cnt_tab [ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [1:0]       wr_cnt;           // current counter at write index
    logic [1:0]       wr_cnt_nxt;

    // word address bits hashed with history
    assign rd_idx = ghr ^ pc[IDX_W+1:2];
    assign wr_idx = ghr ^ commit_pc[IDX_W+1:2]; // history before this commit shifts

    assign prediction = cnt_tab[rd_idx][1]; // msb set -> taken

    assign wr_cnt = cnt_tab[wr_idx];

    // saturating up/down
    always_comb begin
        wr_cnt_nxt = wr_cnt;
        if (commit_taken && (wr_cnt != 2'b11)) begin
            wr_cnt_nxt = wr_cnt + 2'd1;
        end else if (!commit_taken && (wr_cnt != 2'b00)) begin
            wr_cnt_nxt = wr_cnt - 2'd1;
        end
    end

    // training ignores stall, commits come from the backend
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ghr <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                cnt_tab[i] <= 2'b01; // weakly not taken
            end
        end else if (commit_valid) begin
            cnt_tab[wr_idx] <= wr_cnt_nxt;
            ghr             <= {ghr[IDX_W-2:0], commit_taken};
        end
    end

    // a floating commit strobe would corrupt history silently
    commit_known : assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(commit_valid)
    ) else $error("commit_valid unknown");

    // direction must be real whenever it gets shifted in
    taken_known : assert property (
        @(posedge clk) disable iff (!arst_n) commit_valid |-> !$isunknown(commit_taken)
    ) else $error("commit_taken unknown on commit");

endmodule

// File: fetch/return_stack.sv
// return address stack: circular, push/pop/replace from predecode hints, restore on redirect
`timescale 1ns/1ps
`include "fetch_settings.svh"

module return_stack (
    input  logic        clk,
    input  logic        arst_n,
    predecode_if.pred   iface,
    input  logic [31:0] pc,
    input  logic        stall,
    input  logic        redirect,          // mispredict from backend
    input  logic [3:0]  redirect_ras_ptr,  // pointer checkpoint to go back to
    output logic [31:0] top_pc,
    output logic [3:0]  ptr
);

    logic [31:0] stack [`FETCH_RAS_DEPTH];
    logic [31:0] ret_addr;
    logic [3:0]  ptr_inc;

    assign ret_addr = pc + 32'd4;   // link value of the current call
    assign ptr_inc  = ptr + 4'd1;   // wraps, oldest entry gets overwritten
    assign top_pc   = stack[ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
            for (int i = 0; i < `FETCH_RAS_DEPTH; i++) begin
                stack[i] <= '0;
            end
        end else if (redirect) begin
            ptr <= redirect_ras_ptr; // wrong path hints are dropped
        end else if (!stall) begin
            case ({iface.push, iface.pop})
                2'b10: begin
                    ptr          <= ptr_inc;
                    stack[ptr_inc] <= ret_addr;
                end
                2'b01: ptr <= ptr - 4'd1;
                2'b11: stack[ptr] <= ret_addr; // replace top, ptr stays
                default: ;
            endcase
        end
    end

endmodule

// File: fetch/next_pc_select.sv
// pc register and next-pc priority mux: redirect, jal, taken branch, return, sequential
`timescale 1ns/1ps
`include "fetch_settings.svh"

module next_pc_select (
    input  logic        clk,
    input  logic        arst_n,
    predecode_if.sel    iface,
    input  logic        prediction,   // gshare counter msb
    input  logic [31:0] top_pc,       // return stack top
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic [31:0] pc,
    output logic [31:0] next_pc,
    output logic        pred_taken
);

    logic [31:0] seq_pc;

    assign seq_pc     = pc + 32'd4;
    assign pred_taken = iface.jump | (iface.branch & prediction); // jal always taken

    // priority order, redirect wins
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (iface.jump) begin
            next_pc = iface.jal_target;
        end else if (iface.branch && prediction) begin
            next_pc = iface.branch_target;
        end else if (iface.jalr && iface.pop) begin
            next_pc = top_pc; // predicted return
        end else begin
            next_pc = seq_pc;
        end
    end

    // stall freezes pc unless the backend redirects
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `FETCH_RESET_PC;
        end else if (redirect || !stall) begin
            pc <= next_pc;
        end
    end

    // no compressed support, every fetch is word aligned
    pc_aligned : assert property (
        @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
    ) else $error("pc misaligned: %h", pc);

endmodule

// File: design/fetch_unit.sv
// fetch unit top: pc, predecode, gshare and return stack wired to plain ports
`timescale 1ns/1ps

module fetch_unit (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] instr,            // word read at pc, same cycle
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic [3:0]  redirect_ras_ptr,
    input  logic        commit_valid,
    input  logic        commit_taken,
    input  logic [31:0] commit_pc,
    output logic [31:0] pc,
    output logic        pred_taken,
    output logic        is_branch,
    output logic        is_jump,
    output logic [3:0]  ras_ptr,
    output logic [31:0] next_pc
);

    fetch_pkg::instr_u     instr_w;
    fetch_pkg::fetch_out_t fo;
    logic [31:0]           pc_w;
    logic [31:0]           next_pc_w;
    logic [31:0]           top_pc;
    logic [3:0]            ptr;
    logic                  prediction;
    logic                  taken_w;

    predecode_if pd_bus ();

    assign instr_w = instr;

    predecode u_predecode (.iface(pd_bus), .pc(pc_w), .instr(instr_w));

    gshare_predictor u_gshare (
        .clk, .arst_n, .pc(pc_w), .commit_valid, .commit_taken, .commit_pc, .prediction
    );

    return_stack u_ras (
        .clk, .arst_n, .iface(pd_bus), .pc(pc_w), .stall, .redirect,
        .redirect_ras_ptr, .top_pc, .ptr
    );

    next_pc_select u_sel (
        .clk, .arst_n, .iface(pd_bus), .prediction, .top_pc, .stall, .redirect,
        .redirect_pc, .pc(pc_w), .next_pc(next_pc_w), .pred_taken(taken_w)
    );

    // group the fetch result, then split it onto the ports
    assign fo = '{pc: pc_w, instr: instr, pred_taken: taken_w, branch: pd_bus.branch,
                  jump: pd_bus.jump, ras_ptr: ptr, next_pc: next_pc_w};

    assign pc         = fo.pc;
    assign pred_taken = fo.pred_taken;
    assign is_branch  = fo.branch;
    assign is_jump    = fo.jump;
    assign ras_ptr    = fo.ras_ptr;  // before this instruction acts
    assign next_pc    = fo.next_pc;

endmodule

// File: tb/fetch_unit_tb.sv
// fetch unit testbench: sequential fetch, jal, call/return, gshare training, stall and redirect
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_unit_tb;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [3:0]  redirect_ras_ptr;
    logic        commit_valid;
    logic        commit_taken;
    logic [31:0] commit_pc;
    logic [31:0] pc;
    logic        pred_taken;
    logic        is_branch;
    logic        is_jump;
    logic [3:0]  ras_ptr;
    logic [31:0] next_pc;

    logic [31:0]                imem [1024];                    // word slots by pc[11:2]
    logic [`FETCH_GHR_BITS-1:0] ref_ghr;                        // model history
    logic [1:0]                 ref_cnt [1 << `FETCH_GHR_BITS]; // model counters
    logic [3:0]                 ref_ptr;                        // model stack pointer
    logic [31:0]                cur_pc;                         // expected pc right now

    fetch_unit uut (.*);

    always #10 clk = ~clk;

    // instruction port, combinational on pc
    assign instr = $isunknown(pc) ? 32'h0000_0013 : imem[pc[11:2]];

    function automatic logic [31:0] alu_word();
        logic [31:0] w;
        w = $urandom();
        return {w[31:7], 7'b0010011}; // OP-IMM, never control flow
    endfunction

    // word aligned, 32 to 1628 bytes
    function automatic logic [31:0] pick_offset(input logic neg);
        logic [31:0] mag;
        mag = (($urandom() % 400) + 8) * 4;
        return neg ? -mag : mag;
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h000, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    // beq x1, x2
    function automatic logic [31:0] branch_word(input logic [31:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic put(input logic [31:0] addr, input logic [31:0] word);
        imem[addr[11:2]] = word;
    endtask

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2; // drive point
    endtask

    task automatic fetch_at(input logic [31:0] target);
        step();
        #1; // outputs settled
        check_value("pc", target, pc);
        cur_pc = target;
    endtask

    task automatic wait_for_pc(input logic [31:0] target, input int max_cycles);
        int n;
        n = 0;
        while (pc !== target && n < max_cycles) begin
            step();
            n++;
        end
        if (pc !== target) begin
            $display("timeout: pc did not reach %h within %0d cycles", target, max_cycles);
            abort_run();
        end
    endtask

    // pc held at a branch, prediction from the model counters
    task automatic check_branch(input logic [31:0] b, input logic [31:0] off);
        logic exp_t;
        exp_t = ref_cnt[ref_ghr ^ b[11:2]][1];
        check_value("pc", b, pc);
        check_value("is_branch", 1, is_branch);
        check_value("pred_taken", exp_t, pred_taken);
        check_value("next_pc", exp_t ? b + off : b + 4, next_pc);
    endtask

    task automatic reset_sequential();
        cur_pc = `FETCH_RESET_PC;
        wait_for_pc(cur_pc, 4);
        #1;
        check_value("pc", cur_pc, pc);
        check_value("ras_ptr", 0, ras_ptr);
        repeat (8) begin
            check_value("pred_taken", 0, pred_taken);
            check_value("next_pc", cur_pc + 4, next_pc);
            fetch_at(cur_pc + 4);
        end
    endtask

    task automatic jal_direct();
        logic [31:0] p;
        logic [31:0] off;
        logic [3:0]  exp_ptr;
        p   = cur_pc + 4;
        off = pick_offset($urandom() % 2);
        put(p, jal_word(5'd1, off)); // call, pushes p + 4
        put(p + off, alu_word());
        fetch_at(p);
        check_value("ras_ptr", ref_ptr, ras_ptr);
        exp_ptr = ref_ptr + 4'd1;
        check_value("pred_taken", 1, pred_taken);
        check_value("is_jump", 1, is_jump);
        check_value("next_pc", p + off, next_pc);
        fetch_at(p + off);
        check_value("ras_ptr", exp_ptr, ras_ptr);
        ref_ptr = exp_ptr;
    endtask

    task automatic call_return();
        logic [31:0] c;
        logic [31:0] t;
        logic [31:0] d;
        logic [31:0] e;
        logic [3:0]  p0;
        logic [3:0]  p1;
        c = cur_pc + 4;
        t = c + pick_offset(1'b0);  // forward call
        d = c + 4;
        e = d + pick_offset(1'b1);  // backward call, slots never collide
        put(c, jal_word(5'd1, t - c));
        put(t, jalr_word(5'd0, 5'd1));     // ret
        put(d, jal_word(5'd1, e - d));
        put(e, jalr_word(5'd5, 5'd1));     // pop then push, top replaced
        put(d + 4, jalr_word(5'd0, 5'd1));
        put(e + 4, alu_word());
        fetch_at(c);
        p0 = ref_ptr;
        p1 = p0 + 4'd1;
        check_value("ras_ptr", p0, ras_ptr);
        fetch_at(t);
        check_value("ras_ptr", p1, ras_ptr);
        check_value("next_pc", c + 4, next_pc);
        fetch_at(d);
        check_value("ras_ptr", p0, ras_ptr);
        fetch_at(e);
        check_value("ras_ptr", p1, ras_ptr);
        check_value("next_pc", d + 4, next_pc);
        fetch_at(d + 4);
        check_value("ras_ptr", p1, ras_ptr); // replace keeps ptr
        check_value("next_pc", e + 4, next_pc);
        fetch_at(e + 4);
        check_value("ras_ptr", p0, ras_ptr);
    endtask

    task automatic gshare_training();
        logic [31:0]                b;
        logic [31:0]                off;
        logic [`FETCH_GHR_BITS-1:0] idx;
        logic                       taken;
        b   = cur_pc + 4;
        off = pick_offset($urandom() % 2);
        put(b, branch_word(off));
        put(b + off, alu_word());
        step();
        stall = 1'b1; // park pc on the branch
        for (int i = 0; i < 28; i++) begin
            taken        = (i < 16) ? (($urandom() % 2) == 1) : 1'b1; // then a taken run
            commit_valid = 1'b1;
            commit_taken = taken;
            commit_pc    = b;
            #1;
            check_branch(b, off);
            step();
            idx = ref_ghr ^ b[11:2];           // history before the shift
            if (taken && ref_cnt[idx] != 2'b11) begin
                ref_cnt[idx] = ref_cnt[idx] + 2'd1;
            end else if (!taken && ref_cnt[idx] != 2'b00) begin
                ref_cnt[idx] = ref_cnt[idx] - 2'd1;
            end
            ref_ghr      = {ref_ghr[`FETCH_GHR_BITS-2:0], taken};
            commit_valid = 1'b0;
        end
        stall = 1'b0;
        #1;
        check_branch(b, off);
        check_value("pred_taken", 1, pred_taken); // all-ones history saturated
        fetch_at(b + off);
    endtask

    task automatic stall_redirect();
        logic [31:0] s;
        logic [31:0] r;
        logic [3:0]  held;
        logic [3:0]  rptr;
        s = cur_pc + 4;
        put(s, jal_word(5'd1, pick_offset($urandom() % 2))); // would push if it ran
        step();
        stall = 1'b1;
        #1;
        check_value("pc", s, pc);
        held = ref_ptr;
        check_value("ras_ptr", held, ras_ptr);
        repeat (3) begin
            step();
            #1;
            check_value("pc", s, pc);
            check_value("ras_ptr", held, ras_ptr);
        end
        r    = 32'h0000_8000 | ($urandom() & 32'h0000_0ffc);
        rptr = held + 4'd1 + 4'($urandom() % 15); // always differs from held
        put(r, alu_word());
        put(r + 4, alu_word());
        step();
        redirect         = 1'b1; // during stall
        redirect_pc      = r;
        redirect_ras_ptr = rptr;
        #1;
        check_value("next_pc", r, next_pc);
        wait_for_pc(r, 1);
        redirect = 1'b0;
        stall    = 1'b0;
        #1;
        check_value("ras_ptr", rptr, ras_ptr);
        ref_ptr = rptr;
        fetch_at(r + 4);
    endtask

    initial begin
        void'($urandom(32'h4b512b0f));
        clk              = 1'b0;
        arst_n           = 1'b1;
        stall            = 1'b0;
        redirect         = 1'b0;
        redirect_pc      = '0;
        redirect_ras_ptr = '0;
        commit_valid     = 1'b0;
        commit_taken     = 1'b0;
        commit_pc        = '0;
        ref_ghr          = '0;
        ref_ptr          = '0;
        cur_pc           = `FETCH_RESET_PC;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = alu_word();
        end
        for (int i = 0; i < (1 << `FETCH_GHR_BITS); i++) begin
            ref_cnt[i] = 2'b01; // weakly not taken
        end
        #2 arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        reset_sequential();
        jal_direct();
        call_return();
        gshare_training();
        stall_redirect();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: fetch_unit.f
+incdir+common
common/fetch_pkg.sv
common/predecode_if.sv
fetch/predecode.sv
fetch/gshare_predictor.sv
fetch/return_stack.sv
fetch/next_pc_select.sv
design/fetch_unit.sv
tb/fetch_unit_tb.sv
